// ==== src/display_pkg.sv ====
package display_pkg;

  ////////////////////////////////////////
  // Display geometry
  ////////////////////////////////////////
  localparam int num_channels = 8;
  localparam int num_digits   = 8;
  localparam int word_width   = 32;

  // Derived widths
  localparam int sel_w      = $clog2(num_channels);
  localparam int digit_w    = $clog2(num_digits);
  localparam int byte_lanes = word_width / 8;

  ////////////////////////////////////////
  // Scan and blink timing
  ////////////////////////////////////////
  localparam int scan_div    = 4;
  localparam int blink_steps = 32;
  localparam int div_cnt_w   = $clog2(scan_div);
  localparam int blink_cnt_w = $clog2(blink_steps);

  // CPU register after reset, every digit blinking, no points
  localparam logic [word_width-1:0] reset_word = 32'hAA5555AA;

  // Scan states
  localparam logic st_blank = 1'b0;
  localparam logic st_drive = 1'b1;

  // Active low segments, all dark
  localparam logic [7:0] seg_blank = 8'hFF;

endpackage

// ==== src/channel_mux.sv ====
`timescale 1ns/1ps

module channel_mux import display_pkg::*; (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [byte_lanes-1:0]            en,
  input  logic [sel_w-1:0]                 sel,
  input  logic [num_channels*num_digits-1:0] point_in,
  input  logic [num_channels*num_digits-1:0] les,
  input  logic [word_width-1:0]            data0,
  input  logic [word_width-1:0]            data1,
  input  logic [word_width-1:0]            data2,
  input  logic [word_width-1:0]            data3,
  input  logic [word_width-1:0]            data4,
  input  logic [word_width-1:0]            data5,
  input  logic [word_width-1:0]            data6,
  input  logic [word_width-1:0]            data7,
  output logic [word_width-1:0]            disp_num,
  output logic [num_digits-1:0]            le_sel,
  output logic [num_digits-1:0]            point_sel
);

  logic [word_width-1:0] cpu_word;
  logic [num_digits-1:0] cpu_blink;
  logic [num_digits-1:0] cpu_point;

  logic [word_width-1:0] chan_word [num_channels];

  ////////////////////////////////////////
  // CPU display register
  ////////////////////////////////////////

  // Byte lanes load independently, masks follow any write
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cpu_word  <= reset_word;
      cpu_blink <= '1;
      cpu_point <= '0;
    end else begin
      for (int i = 0; i < byte_lanes; i++) begin
        if (en[i]) begin
          cpu_word[i*8 +: 8] <= data0[i*8 +: 8];
        end
      end
      if (|en) begin
        cpu_blink <= les[num_digits-1:0];
        cpu_point <= point_in[num_digits-1:0];
      end
    end
  end

  ////////////////////////////////////////
  // Channel select
  ////////////////////////////////////////

  // Channel 0 is the CPU word, the rest are live inputs
  assign chan_word[0] = cpu_word;
  assign chan_word[1] = data1;
  assign chan_word[2] = data2;
  assign chan_word[3] = data3;
  assign chan_word[4] = data4;
  assign chan_word[5] = data5;
  assign chan_word[6] = data6;
  assign chan_word[7] = data7;

  always_comb begin
    disp_num = chan_word[sel];
    if (sel == '0) begin
      le_sel    = cpu_blink;
      point_sel = cpu_point;
    end else begin
      // Byte k of the mask buses belongs to channel k
      le_sel    = les[sel*num_digits +: num_digits];
      point_sel = point_in[sel*num_digits +: num_digits];
    end
  end

endmodule

// ==== src/scan_timer.sv ====
`timescale 1ns/1ps

module scan_timer import display_pkg::*; (
  input  logic clk,
  input  logic rst,
  output logic step,
  output logic blink_on
);

  logic [div_cnt_w-1:0]   div_cnt;
  logic [blink_cnt_w-1:0] blink_cnt;

  ////////////////////////////////////////
  // Scan step divider
  ////////////////////////////////////////

  // Pulse on the last count of each period
  assign step = (div_cnt == div_cnt_w'(scan_div - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      div_cnt <= '0;
    end else if (step) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Blink phase
  ////////////////////////////////////////

  // Phase flips once per blink_steps scan steps
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      blink_cnt <= '0;
      blink_on  <= 1'b1;
    end else if (step) begin
      if (blink_cnt == blink_cnt_w'(blink_steps - 1)) begin
        blink_cnt <= '0;
        blink_on  <= ~blink_on;
      end else begin
        blink_cnt <= blink_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== src/scan_fsm.sv ====
`timescale 1ns/1ps

module scan_fsm import display_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               step,
  output logic [digit_w-1:0] digit_idx,
  output logic               drive_en
);

  logic               state;
  logic               state_next;
  logic [digit_w-1:0] digit_next;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  // Digits light on alternate steps, blank gap avoids ghosting
  always_comb begin
    state_next = state;
    digit_next = digit_idx;
    if (step) begin
      case (state)
        st_blank: begin
          state_next = st_drive;
        end
        st_drive: begin
          state_next = st_blank;
          if (digit_idx == digit_w'(num_digits - 1)) begin
            digit_next = '0;
          end else begin
            digit_next = digit_idx + 1'b1;
          end
        end
        default: begin
          state_next = st_blank;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // State registers
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= st_blank;
      digit_idx <= '0;
    end else begin
      state     <= state_next;
      digit_idx <= digit_next;
    end
  end

  assign drive_en = (state == st_drive);

endmodule

// ==== src/seg_encoder.sv ====
`timescale 1ns/1ps

module seg_encoder import display_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [word_width-1:0] disp_num,
  input  logic [num_digits-1:0] le_sel,
  input  logic [num_digits-1:0] point_sel,
  input  logic [digit_w-1:0]    digit_idx,
  input  logic                  drive_en,
  input  logic                  blink_on,
  output logic [7:0]            seg,
  output logic [num_digits-1:0] an
);

  logic [3:0]            nibble;
  logic                  blink_bit;
  logic                  point_bit;
  logic [6:0]            hex_seg;
  logic                  dark;

  // Hex glyphs, bit order g f e d c b a, active low
  function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
    case (nib)
      4'h0:    hex_to_seg = 7'h40;
      4'h1:    hex_to_seg = 7'h79;
      4'h2:    hex_to_seg = 7'h24;
      4'h3:    hex_to_seg = 7'h30;
      4'h4:    hex_to_seg = 7'h19;
      4'h5:    hex_to_seg = 7'h12;
      4'h6:    hex_to_seg = 7'h02;
      4'h7:    hex_to_seg = 7'h78;
      4'h8:    hex_to_seg = 7'h00;
      4'h9:    hex_to_seg = 7'h10;
      4'hA:    hex_to_seg = 7'h08;
      4'hB:    hex_to_seg = 7'h03;
      4'hC:    hex_to_seg = 7'h46;
      4'hD:    hex_to_seg = 7'h21;
      4'hE:    hex_to_seg = 7'h06;
      default: hex_to_seg = 7'h0E;
    endcase
  endfunction

  ////////////////////////////////////////
  // Current digit fields
  ////////////////////////////////////////
  assign nibble    = disp_num[digit_idx*4 +: 4];
  assign blink_bit = le_sel[digit_idx];
  assign point_bit = point_sel[digit_idx];
  assign hex_seg   = hex_to_seg(nibble);

  // Blinking digit goes dark in the off phase
  assign dark = blink_bit & ~blink_on;

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      seg <= seg_blank;
      an  <= '1;
    end else begin
      seg <= dark ? seg_blank : {~point_bit, hex_seg};
      an  <= drive_en ? ~(num_digits'(1) << digit_idx) : '1;
    end
  end

endmodule

// ==== src/display_top.sv ====
`timescale 1ns/1ps

module display_top import display_pkg::*; (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [byte_lanes-1:0]              en,
  input  logic [sel_w-1:0]                   sel,
  input  logic [num_channels*num_digits-1:0] point_in,
  input  logic [num_channels*num_digits-1:0] les,
  input  logic [word_width-1:0]              data0,
  input  logic [word_width-1:0]              data1,
  input  logic [word_width-1:0]              data2,
  input  logic [word_width-1:0]              data3,
  input  logic [word_width-1:0]              data4,
  input  logic [word_width-1:0]              data5,
  input  logic [word_width-1:0]              data6,
  input  logic [word_width-1:0]              data7,
  output logic [word_width-1:0]              disp_num,
  output logic [7:0]                         seg,
  output logic [num_digits-1:0]              an
);

  logic [num_digits-1:0] le_sel;
  logic [num_digits-1:0] point_sel;
  logic                  step;
  logic                  blink_on;
  logic [digit_w-1:0]    digit_idx;
  logic                  drive_en;

  ////////////////////////////////////////
  // Channel selection
  ////////////////////////////////////////
  channel_mux u_channel_mux (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .sel       (sel),
    .point_in  (point_in),
    .les       (les),
    .data0     (data0),
    .data1     (data1),
    .data2     (data2),
    .data3     (data3),
    .data4     (data4),
    .data5     (data5),
    .data6     (data6),
    .data7     (data7),
    .disp_num  (disp_num),
    .le_sel    (le_sel),
    .point_sel (point_sel)
  );

  ////////////////////////////////////////
  // Scan timing and sequencing
  ////////////////////////////////////////
  scan_timer u_scan_timer (
    .clk      (clk),
    .rst      (rst),
    .step     (step),
    .blink_on (blink_on)
  );

  scan_fsm u_scan_fsm (
    .clk       (clk),
    .rst       (rst),
    .step      (step),
    .digit_idx (digit_idx),
    .drive_en  (drive_en)
  );

  // Segment and anode drive
  seg_encoder u_seg_encoder (
    .clk       (clk),
    .rst       (rst),
    .disp_num  (disp_num),
    .le_sel    (le_sel),
    .point_sel (point_sel),
    .digit_idx (digit_idx),
    .drive_en  (drive_en),
    .blink_on  (blink_on),
    .seg       (seg),
    .an        (an)
  );

endmodule

// ==== tests/tb_display_top.sv ====
`timescale 1ns/1ps

module tb_display_top import display_pkg::*; ();

  localparam int reset_cycles  = 10;
  localparam int idle_cycles   = 4;
  localparam int write_cycles  = 200;
  localparam int select_cycles = 300;
  localparam int blink_cycles  = 600;
  localparam int mid_reset_len = 3;
  localparam int after_cycles  = 120;
  localparam int total_cycles  = reset_cycles + idle_cycles + write_cycles + select_cycles +
                                 1 + blink_cycles + mid_reset_len + idle_cycles + after_cycles;
  localparam int watchdog_ns   = (total_cycles + 200) * 100;

  // Lit segments per hex digit, bit order g f e d c b a
  localparam logic [6:0] glyph_on [16] = '{
    7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
    7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
  };

  logic                               clk;
  logic                               rst;
  logic [byte_lanes-1:0]              en;
  logic [sel_w-1:0]                   sel;
  logic [num_channels*num_digits-1:0] point_in;
  logic [num_channels*num_digits-1:0] les;
  logic [word_width-1:0]              data_in [num_channels];
  logic [word_width-1:0]              disp_num;
  logic [7:0]                         seg;
  logic [num_digits-1:0]              an;

  integer seed = 32'hc9ff;
  int     blank_hits;

  // Model state
  logic [word_width-1:0] m_cpu_word;
  logic [num_digits-1:0] m_cpu_blink;
  logic [num_digits-1:0] m_cpu_point;
  int                    m_div_cnt;
  int                    m_blink_cnt;
  logic                  m_blink_on;
  logic                  m_drive;
  int                    m_digit;
  logic [7:0]            m_seg;
  logic [num_digits-1:0] m_an;

  display_top u_display_top (
    .clk      (clk),
    .rst      (rst),
    .en       (en),
    .sel      (sel),
    .point_in (point_in),
    .les      (les),
    .data0    (data_in[0]),
    .data1    (data_in[1]),
    .data2    (data_in[2]),
    .data3    (data_in[3]),
    .data4    (data_in[4]),
    .data5    (data_in[5]),
    .data6    (data_in[6]),
    .data7    (data_in[7]),
    .disp_num (disp_num),
    .seg      (seg),
    .an       (an)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic compare_word(input string name, input logic [word_width-1:0] expected,
                              input logic [word_width-1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic compare_seg(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic logic [word_width-1:0] selected_word();
    if (sel == '0) begin
      return m_cpu_word;
    end
    return data_in[sel];
  endfunction

  function automatic logic [num_digits-1:0] selected_blink();
    if (sel == '0) begin
      return m_cpu_blink;
    end
    return les[int'(sel)*num_digits +: num_digits];
  endfunction

  function automatic logic [num_digits-1:0] selected_point();
    if (sel == '0) begin
      return m_cpu_point;
    end
    return point_in[int'(sel)*num_digits +: num_digits];
  endfunction

  task automatic reset_model();
    m_cpu_word  = reset_word;
    m_cpu_blink = '1;
    m_cpu_point = '0;
    m_div_cnt   = 0;
    m_blink_cnt = 0;
    m_blink_on  = 1'b1;
    m_drive     = 1'b0;
    m_digit     = 0;
    m_seg       = seg_blank;
    m_an        = '1;
  endtask

  // One rising edge, using the inputs held before the edge
  task automatic clock_model();
    logic [word_width-1:0] word;
    logic [num_digits-1:0] lmask;
    logic [num_digits-1:0] pmask;
    logic [3:0]            nib;
    logic                  step;
    if (rst) begin
      reset_model();
    end else begin
      word  = selected_word();
      lmask = selected_blink();
      pmask = selected_point();
      nib   = word[m_digit*4 +: 4];
      if (lmask[m_digit] && !m_blink_on) begin
        m_seg = seg_blank;
      end else begin
        m_seg = {~pmask[m_digit], ~glyph_on[nib]};
      end
      m_an = m_drive ? ~(8'h01 << m_digit) : 8'hFF;
      for (int i = 0; i < byte_lanes; i++) begin
        if (en[i]) begin
          m_cpu_word[i*8 +: 8] = data_in[0][i*8 +: 8];
        end
      end
      if (|en) begin
        m_cpu_blink = les[num_digits-1:0];
        m_cpu_point = point_in[num_digits-1:0];
      end
      step = (m_div_cnt == scan_div - 1);
      m_div_cnt = step ? 0 : m_div_cnt + 1;
      if (step) begin
        if (m_blink_cnt == blink_steps - 1) begin
          m_blink_cnt = 0;
          m_blink_on  = ~m_blink_on;
        end else begin
          m_blink_cnt = m_blink_cnt + 1;
        end
        if (m_drive) begin
          m_drive = 1'b0;
          m_digit = (m_digit + 1) % num_digits;
        end else begin
          m_drive = 1'b1;
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus and checking
  ////////////////////////////////////////
  task automatic advance_clock();
    @(posedge clk);
    clock_model();
    #5;
  endtask

  task automatic randomize_data();
    for (int k = 0; k < num_channels; k++) begin
      data_in[k] = $random(seed);
    end
    les      = {$random(seed), $random(seed)};
    point_in = {$random(seed), $random(seed)};
  endtask

  // Sample well before the next edge
  task automatic check_outputs();
    #40;
    compare_word("disp_num", selected_word(), disp_num);
    compare_seg("seg", m_seg, seg);
    compare_seg("an", m_an, an);
    if (m_an != 8'hFF && m_seg == seg_blank) begin
      blank_hits++;
    end
  endtask

  // Reset held for a number of cycles, released in the last one
  task automatic hold_reset(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      advance_clock();
      rst = 1'b1;
      reset_model();
      en  = '0;
      sel = '0;
      randomize_data();
      if (i == cycles - 1) begin
        rst = 1'b0;
      end
      check_outputs();
    end
  endtask

  // No digit lit before the first drive state
  task automatic check_idle();
    repeat (idle_cycles) begin
      advance_clock();
      en  = '0;
      sel = '0;
      randomize_data();
      check_outputs();
      compare_word("disp_num", reset_word, disp_num);
      compare_seg("an", 8'hFF, an);
    end
  endtask

  task automatic run_random(input int cycles, input logic cpu_only, input logic writes);
    repeat (cycles) begin
      advance_clock();
      randomize_data();
      en  = writes ? byte_lanes'($random(seed)) : '0;
      sel = cpu_only ? '0 : sel_w'($random(seed));
      check_outputs();
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    en         = '0;
    sel        = '0;
    les        = '0;
    point_in   = '0;
    blank_hits = 0;
    for (int k = 0; k < num_channels; k++) begin
      data_in[k] = '0;
    end
    reset_model();

    hold_reset(reset_cycles);
    check_idle();

    // Byte lane writes with channel 0 shown
    run_random(write_cycles, 1'b1, 1'b1);
    // Channel selection
    run_random(select_cycles, 1'b0, 1'b1);

    // Load a blink mask with at least one digit set, then let it run
    advance_clock();
    randomize_data();
    les[7:0] = 8'($random(seed)) | 8'h01;
    en       = '1;
    sel      = '0;
    check_outputs();
    run_random(blink_cycles, 1'b1, 1'b0);

    hold_reset(mid_reset_len);
    check_idle();
    run_random(after_cycles, 1'b0, 1'b1);

    if (blank_hits == 0) begin
      $display("Blinking was never seen on a lit digit");
      $display("TEST RESULT: FAIL");
      $fatal(1, "No blink coverage");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  // Watchdog
  initial begin
    #(watchdog_ns);
    $display("Simulation ran past the expected test length and was stopped");
    $display("TEST RESULT: FAIL");
    $fatal(1, "Watchdog timeout");
  end

endmodule

// ==== list.f ====
src/display_pkg.sv
src/channel_mux.sv
src/scan_timer.sv
src/scan_fsm.sv
src/seg_encoder.sv
src/display_top.sv
tests/tb_display_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile with Verilator, run the testbench, check the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tb_display_top \
  -f list.f -o sim_display > build.log 2>&1 \
  || { cat build.log; echo "Compile failed"; exit 1; }

./obj_dir/sim_display > sim.log 2>&1
cat sim.log

grep -qx "TEST RESULT: PASS" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }
